/* logic/conv_mac_array.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_mac_array (
	input  logic                  clk,
	input  logic                  rst_n,
	input  conv_pkg::window_t     window,
	input  logic                  window_valid,
	input  conv_pkg::weight_set_t kernels,
	output conv_pkg::acc_t        result0,
	output conv_pkg::acc_t        result1,
	output conv_pkg::acc_t        result2,
	output logic                  out_valid
);

	logic [1:0]     valid_sr;
	conv_pkg::acc_t lane_sum [conv_pkg::KERNELS];

	// valid follows the two data stages
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_sr <= 2'b00;
		end else begin
			valid_sr <= {valid_sr[0], window_valid};
		end
	end

	assign out_valid = valid_sr[1];

	for (genvar k = 0; k < conv_pkg::KERNELS; k++) begin : g_lane
		logic signed [2*conv_pkg::PIXEL_W-1:0] prod [conv_pkg::TAPS];
		conv_pkg::acc_t                        sum;
		conv_pkg::acc_t                        sum_q;

		// stage 1 registers the products
		always_ff @(posedge clk) begin
			for (int t = 0; t < conv_pkg::TAPS; t++) begin
				prod[t] <= conv_pkg::pixel_t'(
					window[t*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W]) *
					conv_pkg::weight_t'(
					kernels[(k*conv_pkg::TAPS + t)*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W]);
			end
		end

		// full precision adder tree
		always_comb begin
			sum = '0;
			for (int t = 0; t < conv_pkg::TAPS; t++) begin
				sum = sum + conv_pkg::acc_t'(prod[t]);
			end
		end

		// stage 2
		always_ff @(posedge clk) begin
			sum_q <= sum;
		end

		assign lane_sum[k] = sum_q;
	end

	assign result0 = lane_sum[0];
	assign result1 = lane_sum[1];
	assign result2 = lane_sum[2];

endmodule

`default_nettype wire

/* logic/conv_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_pe (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  init,
	input  conv_pkg::row_t        row_in,
	input  conv_pkg::weight_set_t weight_in,
	output conv_pkg::acc_t        result0,
	output conv_pkg::acc_t        result1,
	output conv_pkg::acc_t        result2,
	output logic                  out_valid,
	output logic                  row_take
);

	conv_pkg::window_t     window;
	logic                  window_valid;
	conv_pkg::weight_set_t kernels;

	// line buffer and sweep
	row_window row_window_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.init         (init),
		.row_in       (row_in),
		.window       (window),
		.window_valid (window_valid),
		.row_take     (row_take)
	);

	// weights held through the sweep
	kernel_bank kernel_bank_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.init      (init),
		.weight_in (weight_in),
		.kernels   (kernels)
	);

	// two cycle latency from window to result
	conv_mac_array conv_mac_array_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.window       (window),
		.window_valid (window_valid),
		.kernels      (kernels),
		.result0      (result0),
		.result1      (result1),
		.result2      (result2),
		.out_valid    (out_valid)
	);

endmodule

`default_nettype wire

/* logic/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	// pixel and weight width
	localparam int PIXEL_W = 9;
	localparam int ROW_LEN = 16;
	localparam int KSIZE = 3;
	localparam int TAPS = KSIZE * KSIZE;
	localparam int KERNELS = 3;
	// window positions per sweep
	localparam int COLS_OUT = ROW_LEN - KSIZE + 1;
	// nine signed 9x9 products plus growth
	localparam int ACC_W = 22;

	typedef logic signed [PIXEL_W-1:0] pixel_t;

	typedef logic signed [PIXEL_W-1:0] weight_t;

	typedef logic signed [ACC_W-1:0] acc_t;

	// pixel 0 in the low bits
	typedef logic [ROW_LEN*PIXEL_W-1:0] row_t;

	// tap = row * 3 + column, row 0 is the oldest row
	typedef logic [TAPS*PIXEL_W-1:0] window_t;

	// kernel 0 lowest, same tap order inside each kernel
	typedef logic [KERNELS*TAPS*PIXEL_W-1:0] weight_set_t;

	typedef logic [3:0] col_t;

	typedef enum logic [1:0] {
		ROW_LOAD,
		ROW_SWEEP,
		ROW_SHIFT
	} row_state_t;

endpackage

`default_nettype wire

/* logic/kernel_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_bank (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  init,
	input  conv_pkg::weight_set_t weight_in,
	output conv_pkg::weight_set_t kernels
);

	// one weight per kernel and tap
	conv_pkg::weight_t bank [conv_pkg::KERNELS][conv_pkg::TAPS];

	// last value seen while init is high is kept
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < conv_pkg::KERNELS; k++) begin
				for (int t = 0; t < conv_pkg::TAPS; t++) begin
					bank[k][t] <= '0;
				end
			end
		end else if (init) begin
			for (int k = 0; k < conv_pkg::KERNELS; k++) begin
				for (int t = 0; t < conv_pkg::TAPS; t++) begin
					bank[k][t] <= conv_pkg::weight_t'(
						weight_in[(k*conv_pkg::TAPS + t)*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W]);
				end
			end
		end
	end

	// repack in bus order
	always_comb begin
		kernels = '0;
		for (int k = 0; k < conv_pkg::KERNELS; k++) begin
			for (int t = 0; t < conv_pkg::TAPS; t++) begin
				kernels[(k*conv_pkg::TAPS + t)*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W] =
					bank[k][t];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/row_window.sv */
`timescale 1ns/1ps
`default_nettype none

module row_window (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 init,
	input  conv_pkg::row_t       row_in,
	output conv_pkg::window_t    window,
	output logic                 window_valid,
	output logic                 row_take
);

	conv_pkg::row_state_t state;
	conv_pkg::col_t       col;
	logic [1:0]           load_cnt;
	logic                 loaded;
	conv_pkg::row_t       rows [conv_pkg::KSIZE];
	conv_pkg::window_t    win_sel;

	assign loaded = (load_cnt == 2'(conv_pkg::KSIZE));

	// take only when the shift edge really happens
	assign row_take = (state == conv_pkg::ROW_SHIFT) && !init;

	// control state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= conv_pkg::ROW_LOAD;
			load_cnt     <= 2'd0;
			col          <= '0;
			window_valid <= 1'b0;
		end else begin
			window_valid <= 1'b0;
			if (init) begin
				// init wins from any state
				state <= conv_pkg::ROW_LOAD;
				col   <= '0;
				if (!loaded) begin
					load_cnt <= load_cnt + 2'd1;
				end
			end else begin
				case (state)
					conv_pkg::ROW_LOAD: begin
						// incomplete load restarts on the next init
						load_cnt <= 2'd0;
						if (loaded) begin
							state <= conv_pkg::ROW_SWEEP;
						end
					end
					conv_pkg::ROW_SWEEP: begin
						window_valid <= 1'b1;
						if (col == conv_pkg::col_t'(conv_pkg::COLS_OUT - 1)) begin
							col   <= '0;
							state <= conv_pkg::ROW_SHIFT;
						end else begin
							col <= col + 4'd1;
						end
					end
					conv_pkg::ROW_SHIFT: begin
						state <= conv_pkg::ROW_SWEEP;
					end
					default: begin
						state <= conv_pkg::ROW_LOAD;
					end
				endcase
			end
		end
	end

	// line buffer
	always_ff @(posedge clk) begin
		if (init) begin
			if (!loaded) begin
				rows[load_cnt] <= row_in;
			end
		end else if (state == conv_pkg::ROW_SHIFT) begin
			// oldest row drops out, new row at the bottom
			rows[0] <= rows[1];
			rows[1] <= rows[2];
			rows[2] <= row_in;
		end
	end

	// 3x3 window at the current column
	always_comb begin
		win_sel = '0;
		for (int r = 0; r < conv_pkg::KSIZE; r++) begin
			for (int c = 0; c < conv_pkg::KSIZE; c++) begin
				win_sel[(r*conv_pkg::KSIZE + c)*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W] =
					rows[r][(int'(col) + c)*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!init && state == conv_pkg::ROW_SWEEP) begin
			window <= win_sel;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f src.f --top-module conv_pe_tb -o conv_pe_sim \
	&& ./obj_dir/conv_pe_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& exit 0 \
	|| exit 1

/* src.f */
logic/conv_pkg.sv
logic/row_window.sv
logic/kernel_bank.sv
logic/conv_mac_array.sv
logic/conv_pe.sv
verification/conv_pe_tb.sv

/* verification/conv_pe_golden.txt */
# T name, W 27 weights (kernel 0 first, tap = row*3+col), R 16 pixels of one row
# E kernel then 14 results per sweep, D idle cycles, G load and check
T sweep_rotate
W 1 1 1 1 1 1 1 1 1
1 2 3 0 0 0 0 0 0
-3 0 0 0 0 0 0 0 5
R 0 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15
R 10 11 12 13 14 15 16 17 18 19 20 21 22 23 24 25
R 20 21 22 23 24 25 26 27 28 29 30 31 32 33 34 35
R 30 31 32 33 34 35 36 37 38 39 40 41 42 43 44 45
R 40 41 42 43 44 45 46 47 48 49 50 51 52 53 54 55
R 50 51 52 53 54 55 56 57 58 59 60 61 62 63 64 65
R 60 61 62 63 64 65 66 67 68 69 70 71 72 73 74 75
E 0 99 108 117 126 135 144 153 162 171 180 189 198 207 216
E 1 8 14 20 26 32 38 44 50 56 62 68 74 80 86
E 2 110 112 114 116 118 120 122 124 126 128 130 132 134 136
E 0 189 198 207 216 225 234 243 252 261 270 279 288 297 306
E 1 68 74 80 86 92 98 104 110 116 122 128 134 140 146
E 2 130 132 134 136 138 140 142 144 146 148 150 152 154 156
E 0 279 288 297 306 315 324 333 342 351 360 369 378 387 396
E 1 128 134 140 146 152 158 164 170 176 182 188 194 200 206
E 2 150 152 154 156 158 160 162 164 166 168 170 172 174 176
E 0 369 378 387 396 405 414 423 432 441 450 459 468 477 486
E 1 188 194 200 206 212 218 224 230 236 242 248 254 260 266
E 2 170 172 174 176 178 180 182 184 186 188 190 192 194 196
E 0 459 468 477 486 495 504 513 522 531 540 549 558 567 576
E 1 248 254 260 266 272 278 284 290 296 302 308 314 320 326
E 2 190 192 194 196 198 200 202 204 206 208 210 212 214 216
G
T extremes
W -256 -256 -256 -256 -256 -256 -256 -256 -256
255 255 255 255 255 255 255 255 255
-256 -256 -256 255 255 255 -256 -256 -256
R -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256
R 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255
R -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256 -256
E 0 197376 197376 197376 197376 197376 197376 197376
197376 197376 197376 197376 197376 197376 197376
E 1 -196605 -196605 -196605 -196605 -196605 -196605 -196605
-196605 -196605 -196605 -196605 -196605 -196605 -196605
E 2 588291 588291 588291 588291 588291 588291 588291
588291 588291 588291 588291 588291 588291 588291
G
D 5
T reinit
W 0 0 0 0 1 0 0 0 0
-1 0 1 0 0 0 0 0 0
-1 -1 -1 -1 -1 -1 -1 -1 -1
R -20 -18 -16 -14 -12 -10 -8 -6 -4 -2 0 2 4 6 8 10
R -27 -25 -23 -21 -19 -17 -15 -13 -11 -9 -7 -5 -3 -1 1 3
R -34 -32 -30 -28 -26 -24 -22 -20 -18 -16 -14 -12 -10 -8 -6 -4
R -41 -39 -37 -35 -33 -31 -29 -27 -25 -23 -21 -19 -17 -15 -13 -11
E 0 -25 -23 -21 -19 -17 -15 -13 -11 -9 -7 -5 -3 -1 1
E 1 4 4 4 4 4 4 4 4 4 4 4 4 4 4
E 2 225 207 189 171 153 135 117 99 81 63 45 27 9 -9
E 0 -32 -30 -28 -26 -24 -22 -20 -18 -16 -14 -12 -10 -8 -6
E 1 4 4 4 4 4 4 4 4 4 4 4 4 4 4
E 2 288 270 252 234 216 198 180 162 144 126 108 90 72 54
G

/* verification/conv_pe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_pe_tb;

	logic                  clk;
	logic                  rst_n;
	logic                  init;
	conv_pkg::row_t        row_in;
	conv_pkg::weight_set_t weight_in;
	conv_pkg::acc_t        result0;
	conv_pkg::acc_t        result1;
	conv_pkg::acc_t        result2;
	logic                  out_valid;
	logic                  row_take;

	// golden stimulus and expectations
	conv_pkg::weight_set_t wset;
	conv_pkg::row_t        row_q [$];
	conv_pkg::acc_t        exp0 [$];
	conv_pkg::acc_t        exp1 [$];
	conv_pkg::acc_t        exp2 [$];

	// collected results
	conv_pkg::acc_t        got0 [$];
	conv_pkg::acc_t        got1 [$];
	conv_pkg::acc_t        got2 [$];
	int                    take_cnt;
	int                    idle_events;
	logic                  quiet;
	int                    sweep_res;
	int                    sweep_len [$];
	logic [1:0]            take_dly;

	int                    value_errors;
	int                    count_errors;
	int                    other_errors;
	string                 test_name;
	int                    fd;

	conv_pe dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.init      (init),
		.row_in    (row_in),
		.weight_in (weight_in),
		.result0   (result0),
		.result1   (result1),
		.result2   (result2),
		.out_valid (out_valid),
		.row_take  (row_take)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// sample away from the active edge
	always @(negedge clk) begin
		if (out_valid) begin
			got0.push_back(result0);
			got1.push_back(result1);
			got2.push_back(result2);
			sweep_res++;
		end
		// last result of a sweep trails its shift by the two MAC stages
		if (take_dly[1]) begin
			sweep_len.push_back(sweep_res);
			sweep_res = 0;
		end
		take_dly = {take_dly[0], row_take};
		if (row_take) begin
			take_cnt++;
		end
		if (quiet && (out_valid || row_take)) begin
			idle_events++;
		end
	end

	task automatic note_failure(input string why);
		other_errors++;
		$display("%s", why);
	endtask

	task automatic check_acc(input string name, input conv_pkg::acc_t exp_v,
			input conv_pkg::acc_t act_v);
		if (exp_v !== act_v) begin
			value_errors++;
			$display("Error %s: expected %0d, actual %0d", name, exp_v, act_v);
		end
	endtask

	task automatic check_count(input string name, input int exp_v, input int act_v);
		if (exp_v != act_v) begin
			count_errors++;
			$display("Error %s: expected %0d, actual %0d", name, exp_v, act_v);
		end
	endtask

	task automatic read_int(output int v);
		v = 0;
		if (other_errors == 0 && $fscanf(fd, "%d", v) != 1) begin
			note_failure("golden file ended in the middle of a record");
		end
	endtask

	task automatic wait_row_take();
		int cyc;
		cyc = 0;
		@(negedge clk);
		while (!row_take) begin
			cyc++;
			if (cyc > 4 * conv_pkg::ROW_LEN) begin
				note_failure({"no row_take seen in time during ", test_name});
				return;
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_results(input int n);
		int cyc;
		int limit;
		cyc = 0;
		limit = 2 * n + 50;
		@(negedge clk);
		while (got0.size() < n) begin
			cyc++;
			if (cyc > limit) begin
				note_failure({"results stopped arriving during ", test_name});
				return;
			end
			@(negedge clk);
		end
	endtask

	// init phase loads three rows and the weights
	task automatic load_rows();
		if (row_q.size() < conv_pkg::KSIZE) begin
			note_failure({"fewer than three rows given for ", test_name});
			return;
		end
		@(posedge clk);
		init      <= 1'b1;
		weight_in <= wset;
		row_in    <= row_q.pop_front();
		for (int i = 1; i < conv_pkg::KSIZE; i++) begin
			@(posedge clk);
			row_in <= row_q.pop_front();
		end
		@(posedge clk);
		init      <= 1'b0;
		// weight bus is free once init falls
		weight_in <= '0;
		if (row_q.size() > 0) begin
			row_in <= row_q.pop_front();
		end
		// results from before the reload belong to the old test
		got0.delete();
		got1.delete();
		got2.delete();
		sweep_len.delete();
		sweep_res = 0;
		take_cnt = 0;
		if (quiet) begin
			quiet = 1'b0;
			check_count("reset and init activity", 0, idle_events);
		end
	endtask

	task automatic run_test();
		int n_extra;
		int n;
		n_extra = row_q.size() - conv_pkg::KSIZE;
		n = exp0.size();
		load_rows();
		for (int i = 1; i < n_extra && other_errors == 0; i++) begin
			wait_row_take();
			@(posedge clk);
			row_in <= row_q.pop_front();
		end
		if (other_errors == 0) begin
			wait_results(n);
		end
		if (other_errors != 0) begin
			return;
		end
		check_count({test_name, " row_take count"}, n_extra + 1, take_cnt);
		check_count({test_name, " sweep count"}, n_extra + 1, sweep_len.size());
		foreach (sweep_len[i]) begin
			check_count($sformatf("%s results in sweep %0d", test_name, i),
				conv_pkg::COLS_OUT, sweep_len[i]);
		end
		for (int i = 0; i < n; i++) begin
			check_acc($sformatf("%s k0[%0d]", test_name, i), exp0[i], got0[i]);
			check_acc($sformatf("%s k1[%0d]", test_name, i), exp1[i], got1[i]);
			check_acc($sformatf("%s k2[%0d]", test_name, i), exp2[i], got2[i]);
		end
		exp0.delete();
		exp1.delete();
		exp2.delete();
	endtask

	initial begin
		string tok;
		string line;
		int    v;
		int    k;
		conv_pkg::row_t r;

		rst_n        = 1'b0;
		init         = 1'b0;
		row_in       = '0;
		weight_in    = '0;
		wset         = '0;
		quiet        = 1'b1;
		take_cnt     = 0;
		idle_events  = 0;
		sweep_res    = 0;
		take_dly     = 2'b00;
		value_errors = 0;
		count_errors = 0;
		other_errors = 0;
		test_name    = "reset";

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		fd = $fopen("verification/conv_pe_golden.txt", "r");
		if (fd == 0) begin
			note_failure("cannot open verification/conv_pe_golden.txt");
		end else begin
			while (other_errors == 0 && $fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					void'($fgets(line, fd));
				end else if (tok == "T") begin
					void'($fscanf(fd, "%s", test_name));
				end else if (tok == "W") begin
					for (int i = 0; i < conv_pkg::KERNELS * conv_pkg::TAPS; i++) begin
						read_int(v);
						wset[i*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W] =
							v[conv_pkg::PIXEL_W-1:0];
					end
				end else if (tok == "R") begin
					for (int c = 0; c < conv_pkg::ROW_LEN; c++) begin
						read_int(v);
						r[c*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W] = v[conv_pkg::PIXEL_W-1:0];
					end
					row_q.push_back(r);
				end else if (tok == "E") begin
					read_int(k);
					for (int c = 0; c < conv_pkg::COLS_OUT; c++) begin
						read_int(v);
						case (k)
							0: exp0.push_back(conv_pkg::acc_t'(v));
							1: exp1.push_back(conv_pkg::acc_t'(v));
							default: exp2.push_back(conv_pkg::acc_t'(v));
						endcase
					end
				end else if (tok == "D") begin
					read_int(v);
					repeat (v) @(posedge clk);
				end else if (tok == "G") begin
					run_test();
				end else begin
					note_failure({"unknown record in golden file: ", tok});
				end
			end
			$fclose(fd);
		end

		$display("value errors: %0d, count errors: %0d, other failures: %0d",
			value_errors, count_errors, other_errors);
		if (value_errors == 0 && count_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
